//--- aexmPkg.sv
package aexmPkg;

  typedef logic [31:0] word_t;     // Data word, register value, instruction
  typedef logic [4:0]  regAddr_t;
  typedef logic [5:0]  opcode_t;
  typedef logic [15:0] imm_t;      // Raw immediate field

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_RSUB,   // Operand B minus rA
    ALU_OR,
    ALU_AND,
    ALU_XOR,
    ALU_SHL,
    ALU_SHR,
    ALU_PASS
  } aluOp_t;

  // Decoded control carried from D into X
  typedef struct packed {
    aluOp_t   aluOp;
    logic     useImm;
    logic     regWrite;
    logic     load;
    logic     store;
    logic     branch;
    logic     condBranch;
    logic     condNe;      // BNEI when set, BEQI otherwise
    regAddr_t rd;
  } decodeCtrl_t;

  localparam opcode_t OPC_ADD   = 6'h00;
  localparam opcode_t OPC_RSUB  = 6'h01;
  localparam opcode_t OPC_ADDI  = 6'h08;
  localparam opcode_t OPC_RSUBI = 6'h09;
  localparam opcode_t OPC_BSI   = 6'h19;  // BSLLI and BSRLI
  localparam opcode_t OPC_OR    = 6'h20;
  localparam opcode_t OPC_AND   = 6'h21;
  localparam opcode_t OPC_XOR   = 6'h22;
  localparam opcode_t OPC_ORI   = 6'h28;
  localparam opcode_t OPC_ANDI  = 6'h29;
  localparam opcode_t OPC_XORI  = 6'h2A;
  localparam opcode_t OPC_BRI   = 6'h2E;
  localparam opcode_t OPC_BEQI  = 6'h2F;  // Condition in rd with 0 for EQ and 1 for NE
  localparam opcode_t OPC_LWI   = 6'h3A;
  localparam opcode_t OPC_SWI   = 6'h3E;

  localparam word_t NOP_WORD = 32'h8000_0000;  // OR r0, r0, r0

endpackage

//--- aexmEnable.sv
module aexmEnable (
  input  logic sys_clk_i,
  input  logic rst_i,
  input  logic icacheBusy_i,
  input  logic dcacheBusy_i,
  input  logic fetchStall_i,
  input  logic memOp_i,         // Load or store in X
  output logic cpuEnable_o,
  output logic icacheEnable_o,
  output logic dcacheEnable_o
);

  logic runQ;  // Stays low for the first cycle after reset

  always_ff @(posedge sys_clk_i) begin
    if (rst_i) begin
      runQ <= 1'b0;
    end else begin
      runQ <= 1'b1;
    end
  end

  // Whole pipeline freezes while either cache works
  assign cpuEnable_o    = runQ & ~icacheBusy_i & ~dcacheBusy_i;
  assign icacheEnable_o = cpuEnable_o & ~fetchStall_i;  // No new fetch on load-use
  assign dcacheEnable_o = cpuEnable_o & memOp_i;

  // X control is cleared by reset in the decoder
  assert property (@(posedge sys_clk_i) $past(rst_i) |-> !memOp_i)
    else $error("memory operation in X right after reset");

endmodule

//--- aexmIbuf.sv
module aexmIbuf (
  input  logic              sys_clk_i,
  input  logic              rst_i,
  input  aexmPkg::word_t    icacheDatai_i,
  input  logic              cpuEnable_i,
  input  logic              dSkip_i,
  input  logic              fetchStall_i,
  output aexmPkg::opcode_t  opc_o,
  output aexmPkg::regAddr_t rd_o,
  output aexmPkg::regAddr_t ra_o,
  output aexmPkg::regAddr_t rb_o,
  output aexmPkg::imm_t     imm_o,
  output aexmPkg::word_t    simm_o     // Sign-extended immediate for X
);

  import aexmPkg::*;

  word_t dInst;   // Decode-stage instruction register
  word_t dSimm;

  always_ff @(posedge sys_clk_i) begin
    if (rst_i) begin
      dInst <= NOP_WORD;
    end else if (cpuEnable_i && !fetchStall_i) begin
      dInst <= dSkip_i ? NOP_WORD : icacheDatai_i;  // Squash flushed or empty fetch
    end
  end

  // MicroBlaze field layout
  assign opc_o = dInst[31:26];
  assign rd_o  = dInst[25:21];
  assign ra_o  = dInst[20:16];
  assign rb_o  = dInst[15:11];
  assign imm_o = dInst[15:0];

  assign dSimm = {{16{dInst[15]}}, dInst[15:0]};

  always_ff @(posedge sys_clk_i) begin
    if (rst_i) begin
      simm_o <= '0;
    end else if (cpuEnable_i) begin
      simm_o <= dSimm;
    end
  end

endmodule

//--- aexmCtrl.sv
module aexmCtrl #(
  parameter int BSF = 1
) (
  input  logic                  sys_clk_i,
  input  logic                  rst_i,
  input  aexmPkg::opcode_t      opc_i,
  input  aexmPkg::regAddr_t     rd_i,
  input  aexmPkg::regAddr_t     ra_i,
  input  aexmPkg::regAddr_t     rb_i,
  input  aexmPkg::imm_t         imm_i,
  input  logic                  cpuEnable_i,
  input  logic                  xSkip_i,
  output aexmPkg::decodeCtrl_t  xCtrl_o,
  output logic                  fetchStall_o,
  output logic                  memOp_o,
  output logic                  dcacheWe_o
);

  import aexmPkg::*;

  decodeCtrl_t dCtrl;
  logic        writes;

  always_comb begin
    dCtrl        = '0;
    dCtrl.aluOp  = ALU_PASS;
    dCtrl.useImm = opc_i[3];   // Immediate forms all have bit 3 set
    dCtrl.rd     = rd_i;
    writes       = 1'b1;
    case (opc_i)
      OPC_ADD, OPC_ADDI:   dCtrl.aluOp = ALU_ADD;
      OPC_RSUB, OPC_RSUBI: dCtrl.aluOp = ALU_RSUB;
      OPC_OR, OPC_ORI:     dCtrl.aluOp = ALU_OR;
      OPC_AND, OPC_ANDI:   dCtrl.aluOp = ALU_AND;
      OPC_XOR, OPC_XORI:   dCtrl.aluOp = ALU_XOR;
      OPC_BSI: begin
        dCtrl.aluOp = imm_i[10] ? ALU_SHL : ALU_SHR;
        writes      = (BSF != 0);   // No-op without the shifter
      end
      OPC_LWI:             dCtrl.load = 1'b1;
      OPC_SWI: begin
        dCtrl.store = 1'b1;
        writes      = 1'b0;
      end
      OPC_BRI: begin
        dCtrl.branch = 1'b1;
        writes       = 1'b0;
      end
      OPC_BEQI: begin
        dCtrl.branch     = (rd_i[4:1] == 4'd0);  // Only EQ and NE
        dCtrl.condBranch = 1'b1;
        dCtrl.condNe     = rd_i[0];
        writes           = 1'b0;
      end
      default:             writes = 1'b0;
    endcase
    dCtrl.regWrite = writes && (rd_i != '0);
  end

  // Loaded word is not ready for a D read until the load leaves X
  assign fetchStall_o = xCtrl_o.load && (xCtrl_o.rd != '0)
                        && ((xCtrl_o.rd == ra_i) || (xCtrl_o.rd == rb_i));

  always_ff @(posedge sys_clk_i) begin
    if (rst_i) begin
      xCtrl_o <= '0;
    end else if (cpuEnable_i) begin
      xCtrl_o <= (xSkip_i || fetchStall_o) ? decodeCtrl_t'('0) : dCtrl;  // Bubble
    end
  end

  assign memOp_o    = xCtrl_o.load | xCtrl_o.store;
  assign dcacheWe_o = xCtrl_o.store & cpuEnable_i;

  // Taken branch and load in X never meet
  assert property (@(posedge sys_clk_i) disable iff (rst_i)
                   !(xSkip_i && fetchStall_o))
    else $error("taken branch during load-use stall");

endmodule

//--- aexmBpcu.sv
module aexmBpcu #(
  parameter int IW = 32
) (
  input  logic                 sys_clk_i,
  input  logic                 rst_i,
  input  aexmPkg::decodeCtrl_t xCtrl_i,
  input  aexmPkg::word_t       xRegA_i,
  input  aexmPkg::word_t       xSimm_i,
  input  logic                 cpuEnable_i,
  input  logic                 fetchStall_i,
  output logic [IW-1:0]        icacheAddr_o,
  output logic                 dSkip_o,
  output logic                 xSkip_o
);

  import aexmPkg::*;

  logic [IW-1:0] fetchPc;   // Next sequential fetch
  logic [IW-1:0] busPc;     // Word now on the icache data bus
  logic [IW-1:0] dPc;
  logic [IW-1:0] xPc;
  logic [IW-1:0] target;
  logic          busValid;  // Bus holds a real fetch
  logic          regAZero;
  logic          taken;
  logic          advance;

  assign regAZero = (xRegA_i == '0);
  assign taken    = xCtrl_i.branch
                    & (~xCtrl_i.condBranch | (xCtrl_i.condNe ^ regAZero));
  assign target   = xPc + xSimm_i[IW-1:0];
  assign advance  = cpuEnable_i & ~fetchStall_i;

  // Redirect goes out in the branch's own X cycle
  assign icacheAddr_o = taken ? target : fetchPc;

  always_ff @(posedge sys_clk_i) begin
    if (rst_i) begin
      fetchPc  <= '0;
      busValid <= 1'b0;
    end else if (advance) begin
      fetchPc  <= icacheAddr_o + IW'(4);
      busValid <= 1'b1;
    end
  end

  always_ff @(posedge sys_clk_i) begin
    if (advance) begin
      busPc <= icacheAddr_o;
      dPc   <= busPc;
    end
    if (cpuEnable_i) begin
      xPc <= dPc;
    end
  end

  assign dSkip_o = taken | ~busValid;  // Wrong-path or empty fetch word
  assign xSkip_o = taken;

endmodule

//--- aexmRegf.sv
module aexmRegf (
  input  logic                 sys_clk_i,
  input  logic                 rst_i,
  input  aexmPkg::regAddr_t    ra_i,
  input  aexmPkg::regAddr_t    rb_i,
  input  aexmPkg::regAddr_t    rd_i,
  input  aexmPkg::decodeCtrl_t xCtrl_i,
  input  aexmPkg::word_t       wbResult_i,
  input  aexmPkg::word_t       dcacheDatai_i,
  input  logic                 cpuEnable_i,
  output aexmPkg::word_t       xRegA_o,
  output aexmPkg::word_t       xRegB_o,
  output aexmPkg::word_t       xStoreData_o,
  output aexmPkg::word_t       dcacheDatao_o
);

  import aexmPkg::*;

  word_t    regs [32];
  regAddr_t wbRd;
  logic     wbWrite;
  logic     wbLoad;
  word_t    wbData;
  regAddr_t xRa, xRb, xRd;
  word_t    xRegAQ, xRegBQ, xRdQ;
  word_t    dRegA, dRegB, dRegD;

  assign wbData = wbLoad ? dcacheDatai_i : wbResult_i;

  // Writeback wins over the stored value
  function automatic word_t fwd(regAddr_t addr, word_t value);
    return (wbWrite && (wbRd == addr)) ? wbData : value;
  endfunction

  function automatic word_t readD(regAddr_t addr);
    return (addr == '0) ? '0 : fwd(addr, regs[addr]);  // r0 reads zero
  endfunction

  always_comb begin
    dRegA        = readD(ra_i);
    dRegB        = readD(rb_i);
    dRegD        = readD(rd_i);   // Store data
    xRegA_o      = fwd(xRa, xRegAQ);
    xRegB_o      = fwd(xRb, xRegBQ);
    xStoreData_o = fwd(xRd, xRdQ);
  end

  assign dcacheDatao_o = xStoreData_o;

  always_ff @(posedge sys_clk_i) begin
    if (cpuEnable_i && wbWrite) begin
      regs[wbRd] <= wbData;   // Decoder never writes r0
    end
  end

  always_ff @(posedge sys_clk_i) begin
    if (rst_i) begin
      wbWrite <= 1'b0;
    end else if (cpuEnable_i) begin
      wbWrite <= xCtrl_i.regWrite;
    end
  end

  always_ff @(posedge sys_clk_i) begin
    if (cpuEnable_i) begin
      wbRd   <= xCtrl_i.rd;
      wbLoad <= xCtrl_i.load;
      xRa    <= ra_i;
      xRb    <= rb_i;
      xRd    <= rd_i;
      xRegAQ <= dRegA;
      xRegBQ <= dRegB;
      xRdQ   <= dRegD;
    end
  end

endmodule

//--- aexmXecu.sv
module aexmXecu #(
  parameter int DW  = 32,
  parameter int BSF = 1
) (
  input  logic                 sys_clk_i,
  input  logic                 rst_i,
  input  aexmPkg::decodeCtrl_t xCtrl_i,
  input  aexmPkg::word_t       xRegA_i,
  input  aexmPkg::word_t       xRegB_i,
  input  aexmPkg::word_t       xSimm_i,
  input  logic                 cpuEnable_i,
  output logic [DW-1:0]        dcacheAddr_o,
  output aexmPkg::word_t       wbResult_o
);

  import aexmPkg::*;

  word_t opB;
  word_t shlRes;
  word_t shrRes;
  word_t aluRes;
  word_t memAddr;

  assign opB = xCtrl_i.useImm ? xSimm_i : xRegB_i;

  generate
    if (BSF != 0) begin : gShift
      assign shlRes = xRegA_i << opB[4:0];
      assign shrRes = xRegA_i >> opB[4:0];   // Logical
    end else begin : gNoShift
      assign shlRes = '0;   // Shift ops decode as no-ops here
      assign shrRes = '0;
    end
  endgenerate

  always_comb begin
    case (xCtrl_i.aluOp)
      ALU_ADD:  aluRes = xRegA_i + opB;
      ALU_RSUB: aluRes = opB - xRegA_i;
      ALU_OR:   aluRes = xRegA_i | opB;
      ALU_AND:  aluRes = xRegA_i & opB;
      ALU_XOR:  aluRes = xRegA_i ^ opB;
      ALU_SHL:  aluRes = shlRes;
      ALU_SHR:  aluRes = shrRes;
      default:  aluRes = opB;   // ALU_PASS
    endcase
  end

  // Effective address for LWI and SWI
  assign memAddr      = xRegA_i + xSimm_i;
  assign dcacheAddr_o = memAddr[DW-1:0];

  always_ff @(posedge sys_clk_i) begin
    if (rst_i) begin
      wbResult_o <= '0;
    end else if (cpuEnable_i) begin
      wbResult_o <= aluRes;
    end
  end

endmodule

//--- aexmCore.sv
module aexmCore #(
  parameter int IW  = 32,
  parameter int DW  = 32,
  parameter int BSF = 1
) (
  input  logic           sys_clk_i,
  input  logic           rst_i,
  output logic [IW-1:0]  icachePrecycleAddr_o,
  output logic           icachePrecycleEnable_o,
  input  aexmPkg::word_t icacheDatai_i,
  input  logic           icacheBusy_i,
  output logic [DW-1:0]  dcachePrecycleAddr_o,
  output logic           dcachePrecycleEnable_o,
  output logic           dcachePrecycleWe_o,
  output aexmPkg::word_t dcacheDatao_o,
  input  aexmPkg::word_t dcacheDatai_i,
  input  logic           dcacheBusy_i
);

  import aexmPkg::*;

  logic        cpuEnable;
  logic        fetchStall;
  logic        memOp;
  logic        dSkip;
  logic        xSkip;
  opcode_t     opc;
  regAddr_t    rd;
  regAddr_t    ra;
  regAddr_t    rb;
  imm_t        imm;
  word_t       xSimm;
  word_t       xRegA;
  word_t       xRegB;
  word_t       wbResult;
  decodeCtrl_t xCtrl;

  aexmEnable u_enable (
    .sys_clk_i, .rst_i, .icacheBusy_i, .dcacheBusy_i,
    .fetchStall_i(fetchStall), .memOp_i(memOp), .cpuEnable_o(cpuEnable),
    .icacheEnable_o(icachePrecycleEnable_o), .dcacheEnable_o(dcachePrecycleEnable_o));

  aexmIbuf u_ibuf (
    .sys_clk_i, .rst_i, .icacheDatai_i, .cpuEnable_i(cpuEnable),
    .dSkip_i(dSkip), .fetchStall_i(fetchStall), .opc_o(opc),
    .rd_o(rd), .ra_o(ra), .rb_o(rb), .imm_o(imm), .simm_o(xSimm));

  aexmCtrl #(.BSF(BSF)) u_ctrl (
    .sys_clk_i, .rst_i, .opc_i(opc), .rd_i(rd), .ra_i(ra), .rb_i(rb),
    .imm_i(imm), .cpuEnable_i(cpuEnable), .xSkip_i(xSkip), .xCtrl_o(xCtrl),
    .fetchStall_o(fetchStall), .memOp_o(memOp), .dcacheWe_o(dcachePrecycleWe_o));

  aexmBpcu #(.IW(IW)) u_bpcu (
    .sys_clk_i, .rst_i, .xCtrl_i(xCtrl), .xRegA_i(xRegA), .xSimm_i(xSimm),
    .cpuEnable_i(cpuEnable), .fetchStall_i(fetchStall),
    .icacheAddr_o(icachePrecycleAddr_o), .dSkip_o(dSkip), .xSkip_o(xSkip));

  aexmRegf u_regf (
    .sys_clk_i, .rst_i, .ra_i(ra), .rb_i(rb), .rd_i(rd), .xCtrl_i(xCtrl),
    .wbResult_i(wbResult), .dcacheDatai_i, .cpuEnable_i(cpuEnable),
    .xRegA_o(xRegA), .xRegB_o(xRegB), .xStoreData_o(), .dcacheDatao_o);

  aexmXecu #(.DW(DW), .BSF(BSF)) u_xecu (
    .sys_clk_i, .rst_i, .xCtrl_i(xCtrl), .xRegA_i(xRegA), .xRegB_i(xRegB),
    .xSimm_i(xSimm), .cpuEnable_i(cpuEnable),
    .dcacheAddr_o(dcachePrecycleAddr_o), .wbResult_o(wbResult));

endmodule

//--- tbMem.sv
module tbMem (
  input  logic           sys_clk_i,
  input  logic [31:0]    iAddr_i,
  input  logic           iEnable_i,
  output aexmPkg::word_t iData_o,
  output logic           iBusy_o,
  input  logic [31:0]    dAddr_i,
  input  logic           dEnable_i,
  input  logic           dWe_i,
  input  aexmPkg::word_t dData_i,
  output aexmPkg::word_t dData_o,
  output logic           dBusy_o
);

  timeunit 1ns;
  timeprecision 1ps;

  import aexmPkg::*;

  word_t  rom [64];   // Loaded by the testbench top
  word_t  ram [64];
  integer seed;

  initial begin
    seed    = 4091;
    iData_o = '0;
    dData_o = '0;
    iBusy_o = 1'b0;
    dBusy_o = 1'b0;
  end

  // Enables only rise while both busy lines are low, so each one is an accepted access
  always @(posedge sys_clk_i) begin
    iBusy_o <= (($random(seed) & 3) == 0);  // About one cycle in four
    dBusy_o <= (($random(seed) & 3) == 0);
    if (iEnable_i) begin
      iData_o <= rom[iAddr_i[7:2]];
    end
    if (dEnable_i && dWe_i) begin
      ram[dAddr_i[7:2]] <= dData_i;
    end else if (dEnable_i) begin
      dData_o <= ram[dAddr_i[7:2]];
    end
  end

endmodule

//--- tbAexmCore.sv
module tbAexmCore;

  timeunit 1ns;
  timeprecision 1ps;

  import aexmPkg::*;

  localparam word_t FINAL_ADDR = 32'h0000_00FC;

  logic        sys_clk_i;
  logic        rst_i;
  logic [31:0] iAddr, dAddr;
  logic        iEnable, dEnable, dWe, iBusy, dBusy;
  word_t       iData, dDataOut, dDataIn;

  word_t prog [64];
  word_t refRam [64];
  word_t expAddrQ [$];
  word_t expDataQ [$];
  word_t ea, ed;
  int    aluErrs, loadErrs, branchErrs, resetErrs, imageErrs;
  int    testPass, testFail;
  logic  finalSeen;
  int    i, cycles;

  aexmCore #(.IW(32), .DW(32), .BSF(1)) u_dut (
    .sys_clk_i, .rst_i,
    .icachePrecycleAddr_o(iAddr), .icachePrecycleEnable_o(iEnable),
    .icacheDatai_i(iData), .icacheBusy_i(iBusy),
    .dcachePrecycleAddr_o(dAddr), .dcachePrecycleEnable_o(dEnable),
    .dcachePrecycleWe_o(dWe), .dcacheDatao_o(dDataOut),
    .dcacheDatai_i(dDataIn), .dcacheBusy_i(dBusy));

  tbMem u_mem (
    .sys_clk_i, .iAddr_i(iAddr), .iEnable_i(iEnable), .iData_o(iData),
    .iBusy_o(iBusy), .dAddr_i(dAddr), .dEnable_i(dEnable), .dWe_i(dWe),
    .dData_i(dDataOut), .dData_o(dDataIn), .dBusy_o(dBusy));

  initial begin
    sys_clk_i = 1'b0;
    forever #20 sys_clk_i = ~sys_clk_i;
  end

  function automatic word_t encA(opcode_t op, int rd, int ra, int rb);
    return {op, rd[4:0], ra[4:0], rb[4:0], 11'd0};
  endfunction

  function automatic word_t encB(opcode_t op, int rd, int ra, logic [15:0] imm);
    return {op, rd[4:0], ra[4:0], imm};
  endfunction

  // Whole byte address goes into the pattern
  function automatic word_t fillWord(int idx);
    logic [15:0] a;
    a = 16'(idx << 2);
    return {a ^ 16'hA5A5, ~a};
  endfunction

  // Sequential ISA model with one instruction per step
  function automatic void refRun();
    word_t    r [32];
    word_t    ins, pc, nextPc, simm, res, addr;
    opcode_t  op;
    regAddr_t rd, ra, rb;
    logic     wr;
    logic     done;
    for (int k = 0; k < 32; k++) r[k] = '0;
    for (int k = 0; k < 64; k++) refRam[k] = fillWord(k);
    pc   = '0;
    done = 1'b0;
    for (int step = 0; step < 500 && !done; step++) begin
      ins    = prog[pc[7:2]];
      op     = ins[31:26];
      rd     = ins[25:21];
      ra     = ins[20:16];
      rb     = ins[15:11];
      simm   = {{16{ins[15]}}, ins[15:0]};
      addr   = r[ra] + simm;
      nextPc = pc + 4;
      wr     = 1'b1;
      res    = '0;
      case (op)
        OPC_ADD:   res = r[ra] + r[rb];
        OPC_ADDI:  res = r[ra] + simm;
        OPC_RSUB:  res = r[rb] - r[ra];
        OPC_RSUBI: res = simm - r[ra];
        OPC_OR:    res = r[ra] | r[rb];
        OPC_AND:   res = r[ra] & r[rb];
        OPC_XOR:   res = r[ra] ^ r[rb];
        OPC_ORI:   res = r[ra] | simm;
        OPC_ANDI:  res = r[ra] & simm;
        OPC_XORI:  res = r[ra] ^ simm;
        OPC_BSI:   res = ins[10] ? (r[ra] << ins[4:0]) : (r[ra] >> ins[4:0]);
        OPC_LWI:   res = refRam[addr[7:2]];
        OPC_SWI: begin
          wr = 1'b0;
          refRam[addr[7:2]] = r[rd];
          expAddrQ.push_back(addr);
          expDataQ.push_back(r[rd]);
        end
        OPC_BRI: begin
          wr     = 1'b0;
          done   = (simm == '0);  // Self-branch ends the program
          nextPc = pc + simm;
        end
        OPC_BEQI: begin
          wr = 1'b0;
          if ((rd == 0 && r[ra] == '0) || (rd == 1 && r[ra] != '0)) begin
            nextPc = pc + simm;
          end
        end
        default:   wr = 1'b0;
      endcase
      if (wr && rd != 0) r[rd] = res;
      pc = nextPc;
    end
  endfunction

  task automatic reportTest(string name, int errs);
    if (errs == 0) begin
      testPass++;
      $display("test %s: ok", name);
    end else begin
      testFail++;
      $display("test %s: %0d error(s)", name, errs);
    end
  endtask

  task automatic expectLow(string name, logic value);
    assert (value == 1'b0) else begin
      $display("[FAIL] %0t %s got %b expected 0", $time, name, value);
      resetErrs++;
    end
  endtask

  task automatic buildProgram();
    for (int k = 0; k < 64; k++) prog[k] = NOP_WORD;
    prog[0]  = encB(OPC_ADDI, 1, 0, 16'h1234);
    prog[1]  = encB(OPC_ADDI, 2, 0, 16'hFFFB);
    prog[2]  = encA(OPC_ADD, 3, 1, 2);             // Depends on both previous
    prog[3]  = encB(OPC_SWI, 3, 0, 16'h0080);
    prog[4]  = encA(OPC_RSUB, 4, 1, 3);
    prog[5]  = encB(OPC_SWI, 4, 0, 16'h0084);
    prog[6]  = encB(OPC_RSUBI, 5, 1, 16'd100);
    prog[7]  = encB(OPC_SWI, 5, 0, 16'h0088);
    prog[8]  = encA(OPC_OR, 6, 1, 2);
    prog[9]  = encA(OPC_AND, 7, 6, 1);
    prog[10] = encA(OPC_XOR, 8, 7, 2);
    prog[11] = encB(OPC_SWI, 8, 0, 16'h008C);
    prog[12] = encB(OPC_ORI, 9, 8, 16'h0F0F);
    prog[13] = encB(OPC_ANDI, 10, 9, 16'h7FF0);
    prog[14] = encB(OPC_XORI, 11, 10, 16'hFFFF);
    prog[15] = encB(OPC_SWI, 11, 0, 16'h0090);
    prog[16] = encB(OPC_BSI, 12, 1, 16'h0407);     // BSLLI by 7
    prog[17] = encB(OPC_BSI, 13, 12, 16'h0003);    // BSRLI by 3
    prog[18] = encB(OPC_SWI, 13, 0, 16'h0094);
    prog[19] = encB(OPC_LWI, 14, 0, 16'h0010);
    prog[20] = encA(OPC_ADD, 15, 14, 1);           // Load-use
    prog[21] = encB(OPC_SWI, 15, 0, 16'h0098);
    prog[22] = encB(OPC_BRI, 0, 0, 16'd12);
    prog[23] = encB(OPC_SWI, 1, 0, 16'h00E0);      // Wrong path
    prog[24] = encB(OPC_SWI, 1, 0, 16'h00E4);
    prog[25] = encB(OPC_SWI, 2, 0, 16'h009C);
    prog[26] = encB(OPC_BEQI, 0, 0, 16'd12);       // Taken since r0 is zero
    prog[27] = encB(OPC_SWI, 1, 0, 16'h00E8);
    prog[28] = encB(OPC_SWI, 1, 0, 16'h00EC);
    prog[29] = encB(OPC_SWI, 3, 0, 16'h00A0);
    prog[30] = encB(OPC_BEQI, 1, 0, 16'd8);        // BNEI on r0 is not taken
    prog[31] = encB(OPC_SWI, 4, 0, 16'h00A4);
    prog[32] = encB(OPC_SWI, 15, 0, 16'h00FC);     // End marker
    prog[33] = encB(OPC_BRI, 0, 0, 16'd0);
  endtask

  // Stores are sampled at the falling edge where everything is settled
  always @(negedge sys_clk_i) begin
    if (!rst_i && dWe) begin
      if (expAddrQ.size() == 0) begin
        $display("Store to %h at %0t came after the expected sequence had ended", dAddr, $time);
        branchErrs++;
      end else begin
        ea = expAddrQ.pop_front();
        ed = expDataQ.pop_front();
        assert (dAddr == ea) else begin
          $display("[FAIL] %0t dcachePrecycleAddr_o got %h expected %h", $time, dAddr, ea);
          if (ea >= 32'h9C) begin
            branchErrs++;
          end else begin
            aluErrs++;
          end
        end
        assert (dDataOut == ed) else begin
          $display("[FAIL] %0t dcacheDatao_o got %h expected %h", $time, dDataOut, ed);
          if (ea == 32'h98) begin
            loadErrs++;
          end else if (ea >= 32'h9C) begin
            branchErrs++;
          end else begin
            aluErrs++;
          end
        end
        if (dAddr == FINAL_ADDR) finalSeen = 1'b1;
      end
    end
  end

  initial begin
    rst_i     = 1'b1;
    finalSeen = 1'b0;
    aluErrs   = 0;
    loadErrs  = 0;
    branchErrs = 0;
    resetErrs = 0;
    imageErrs = 0;
    testPass  = 0;
    testFail  = 0;
    buildProgram();
    refRun();
    for (i = 0; i < 64; i++) begin
      u_mem.rom[i] = prog[i];
      u_mem.ram[i] = fillWord(i);
    end

    // Reset plus the first cycle after release
    for (i = 0; i < 9; i++) begin
      @(negedge sys_clk_i);
      expectLow("icachePrecycleEnable_o", iEnable);
      expectLow("dcachePrecycleEnable_o", dEnable);
      expectLow("dcachePrecycleWe_o", dWe);
      if (i == 7) begin
        @(posedge sys_clk_i);
        rst_i <= 1'b0;
      end
    end
    cycles = 0;
    while (!iEnable && cycles < 50) begin
      @(negedge sys_clk_i);
      cycles++;
    end
    if (!iEnable) begin
      $display("No instruction fetch within 50 cycles of reset release");
      $display("SIMULATION FAILED");
      $finish;
    end
    assert (iAddr == '0) else begin
      $display("[FAIL] %0t icachePrecycleAddr_o got %h expected %h", $time, iAddr, 32'h0);
      resetErrs++;
    end
    reportTest("reset and first fetch", resetErrs);

    cycles = 0;
    while (!finalSeen && cycles < 2000) begin
      @(negedge sys_clk_i);
      cycles++;
    end
    if (!finalSeen) begin
      $display("End marker store not seen within 2000 cycles");
      $display("SIMULATION FAILED");
      $finish;
    end
    repeat (4) @(negedge sys_clk_i);
    if (expAddrQ.size() != 0) begin
      $display("%0d expected stores never appeared", expAddrQ.size());
      branchErrs++;
    end
    for (i = 0; i < 64; i++) begin
      assert (u_mem.ram[i] == refRam[i]) else begin
        $display("[FAIL] %0t ram[%0d] got %h expected %h", $time, i, u_mem.ram[i], refRam[i]);
        imageErrs++;
      end
    end
    reportTest("arithmetic, logic and shifts", aluErrs);
    reportTest("load and load-use", loadErrs);
    reportTest("branches and flush", branchErrs);
    reportTest("data memory image under busy", imageErrs);

    $display("tests passed %0d, failed %0d", testPass, testFail);
    if (testFail == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- aexmCore.f
aexmPkg.sv
aexmEnable.sv
aexmIbuf.sv
aexmCtrl.sv
aexmBpcu.sv
aexmRegf.sv
aexmXecu.sv
aexmCore.sv
tbMem.sv
tbAexmCore.sv
